// File: verilog/cpuPkg.sv
// Widths, encodings and control word layouts shared by the whole core
// Microroutine addresses here must agree with the table in microProgramRom
// No interrupts, stack or indexed modes in this instruction set
`default_nettype none

package cpuPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and fixed addresses

    localparam int dataWidth  = 8;                            // Data bus and registers
    localparam int addrWidth  = 16;                           // External address bus
    localparam int uAddrWidth = 5;                            // 32 microwords

    localparam logic [addrWidth-1:0] resetVector = 16'h0200;  // First fetch after reset

    ////////////////////////////////////////////////////////////////////////////
    // Control field encodings

    typedef enum logic [1:0] {
        ioNone  = 2'b00,                                      // Internal cycle
        ioWrite = 2'b01,
        ioRead  = 2'b10,
        ioFetch = 2'b11                                       // Opcode fetch
    } ioOpE;

    typedef enum logic [1:0] {
        seqNext,                                              // uPc + 1
        seqBranch,                                            // Take branchAddr
        seqDispatch                                           // Take opcode entry
    } seqOpE;

    typedef enum logic [2:0] {
        naHold,
        naPcInc,
        naMarFromOps,                                         // MAR <= {op2, op1}
        naPcFromOps,                                          // AO = {op2, op1}, PC one past
        naUseMar
    } naOpE;

    typedef enum logic [2:0] {
        aluNone, aluLoad, aluAdd, aluAnd, aluOr, aluXor, aluClc, aluSec
    } aluOpE;

    // Supported 6502 opcodes
    typedef enum logic [7:0] {
        opLdaImm = 8'hA9,
        opLdaAbs = 8'hAD,
        opStaAbs = 8'h8D,
        opAdcImm = 8'h69,
        opAndImm = 8'h29,
        opOraImm = 8'h09,
        opEorImm = 8'h49,
        opJmpAbs = 8'h4C,
        opClc    = 8'h18,
        opSec    = 8'h38,
        opNop    = 8'hEA
    } opcodeE;

    // Microroutine start addresses
    localparam logic [uAddrWidth-1:0] uFetch    = 5'd0;
    localparam logic [uAddrWidth-1:0] uImm      = 5'd1;
    localparam logic [uAddrWidth-1:0] uLdaLo    = 5'd2;
    localparam logic [uAddrWidth-1:0] uLdaHi    = 5'd3;
    localparam logic [uAddrWidth-1:0] uLdaRead  = 5'd4;
    localparam logic [uAddrWidth-1:0] uStaLo    = 5'd5;
    localparam logic [uAddrWidth-1:0] uStaHi    = 5'd6;
    localparam logic [uAddrWidth-1:0] uStaWrite = 5'd7;
    localparam logic [uAddrWidth-1:0] uJmpLo    = 5'd8;
    localparam logic [uAddrWidth-1:0] uJmpHi    = 5'd9;
    localparam logic [uAddrWidth-1:0] uJmpLoad  = 5'd10;

    ////////////////////////////////////////////////////////////////////////////
    // Control words

    typedef struct packed {
        seqOpE                  seqOp;
        logic [uAddrWidth-1:0]  branchAddr;
        ioOpE                   ioOp;
        naOpE                   naOp;
        logic                   ldOp1;                        // op1 <= DI
        logic                   ldOp2;                        // op2 <= DI
        logic                   aluEn;                        // Run the decoded ALU op
    } microWordT;

    typedef struct packed {
        aluOpE                  aluOp;
        logic [uAddrWidth-1:0]  entry;                        // Microroutine start
    } decodeT;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
    } flagsT;

    // Fetch word also serves as the reset value of the microword register
    localparam microWordT fetchWord = '{seqOp: seqDispatch, branchAddr: uFetch,
                                        ioOp: ioFetch, naOp: naPcInc,
                                        ldOp1: 1'b0, ldOp2: 1'b0, aluEn: 1'b1};

endpackage

`default_nettype wire

// File: verilog/microSequencer.sv
// Microprogram address sequencer
// uAddr is the next microaddress, fed to the registered microprogram ROM
`timescale 1ns/1ps
`default_nettype none

module microSequencer (
    input  wire                                 Clk,
    input  wire                                 rst,
    input  wire                                 rdy,      // Core clock enable
    input  wire cpuPkg::microWordT              uWord,    // Current microword
    input  wire [cpuPkg::uAddrWidth-1:0]        entry,    // Opcode entry from decoder
    output logic [cpuPkg::uAddrWidth-1:0]       uAddr
);

    logic [cpuPkg::uAddrWidth-1:0] uPc;                   // Address of current microword

    // Next address select
    always_comb
    begin
        case (uWord.seqOp)
            cpuPkg::seqNext:     uAddr = uPc + 1'b1;
            cpuPkg::seqBranch:   uAddr = uWord.branchAddr;
            cpuPkg::seqDispatch: uAddr = entry;           // Same edge as decode load
            default:             uAddr = uPc;             // Spare code holds
        endcase
    end

    // Tracks the ROM register so seqNext counts from the running word
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            uPc <= cpuPkg::uFetch;
        end
        else if (rdy)
        begin
            uPc <= uAddr;
        end
    end

endmodule

`default_nettype wire

// File: verilog/microProgramRom.sv
// Microcode table with the registered microword
// Unused addresses return the fetch word
`timescale 1ns/1ps
`default_nettype none

module microProgramRom (
    input  wire                             Clk,
    input  wire                             rst,
    input  wire                             rdy,
    input  wire [cpuPkg::uAddrWidth-1:0]    uAddr,
    output cpuPkg::microWordT               uWord
);

    cpuPkg::microWordT romWord;

    ////////////////////////////////////////////////////////////////////////////
    // Microroutines

    always_comb
    begin
        case (uAddr)
            cpuPkg::uFetch: romWord = cpuPkg::fetchWord;
            // Immediate operand, ALU op runs during the next fetch
            cpuPkg::uImm: romWord = '{seqOp: cpuPkg::seqBranch, branchAddr: cpuPkg::uFetch,
                ioOp: cpuPkg::ioRead, naOp: cpuPkg::naPcInc,
                ldOp1: 1'b1, ldOp2: 1'b0, aluEn: 1'b0};
            cpuPkg::uLdaLo: romWord = '{seqOp: cpuPkg::seqNext, branchAddr: cpuPkg::uFetch,
                ioOp: cpuPkg::ioRead, naOp: cpuPkg::naPcInc,
                ldOp1: 1'b1, ldOp2: 1'b0, aluEn: 1'b0};
            cpuPkg::uLdaHi: romWord = '{seqOp: cpuPkg::seqNext, branchAddr: cpuPkg::uFetch,
                ioOp: cpuPkg::ioRead, naOp: cpuPkg::naPcInc,
                ldOp1: 1'b0, ldOp2: 1'b1, aluEn: 1'b0};
            // Data byte goes to op1 for aluLoad
            cpuPkg::uLdaRead: romWord = '{seqOp: cpuPkg::seqBranch, branchAddr: cpuPkg::uFetch,
                ioOp: cpuPkg::ioRead, naOp: cpuPkg::naMarFromOps,
                ldOp1: 1'b1, ldOp2: 1'b0, aluEn: 1'b0};
            cpuPkg::uStaLo: romWord = '{seqOp: cpuPkg::seqNext, branchAddr: cpuPkg::uFetch,
                ioOp: cpuPkg::ioRead, naOp: cpuPkg::naPcInc,
                ldOp1: 1'b1, ldOp2: 1'b0, aluEn: 1'b0};
            cpuPkg::uStaHi: romWord = '{seqOp: cpuPkg::seqNext, branchAddr: cpuPkg::uFetch,
                ioOp: cpuPkg::ioRead, naOp: cpuPkg::naPcInc,
                ldOp1: 1'b0, ldOp2: 1'b1, aluEn: 1'b0};
            cpuPkg::uStaWrite: romWord = '{seqOp: cpuPkg::seqBranch, branchAddr: cpuPkg::uFetch,
                ioOp: cpuPkg::ioWrite, naOp: cpuPkg::naMarFromOps,
                ldOp1: 1'b0, ldOp2: 1'b0, aluEn: 1'b0};
            cpuPkg::uJmpLo: romWord = '{seqOp: cpuPkg::seqNext, branchAddr: cpuPkg::uFetch,
                ioOp: cpuPkg::ioRead, naOp: cpuPkg::naPcInc,
                ldOp1: 1'b1, ldOp2: 1'b0, aluEn: 1'b0};
            cpuPkg::uJmpHi: romWord = '{seqOp: cpuPkg::seqNext, branchAddr: cpuPkg::uFetch,
                ioOp: cpuPkg::ioRead, naOp: cpuPkg::naHold,
                ldOp1: 1'b0, ldOp2: 1'b1, aluEn: 1'b0};
            // Opcode fetch at the target while the PC moves past it
            cpuPkg::uJmpLoad: romWord = '{seqOp: cpuPkg::seqDispatch,
                branchAddr: cpuPkg::uFetch, ioOp: cpuPkg::ioFetch, naOp: cpuPkg::naPcFromOps,
                ldOp1: 1'b0, ldOp2: 1'b0, aluEn: 1'b1};
            default: romWord = cpuPkg::fetchWord;
        endcase
    end

    // Pipeline register, holds while the bus waits
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            uWord <= cpuPkg::fetchWord;
        end
        else if (rdy)
        begin
            uWord <= romWord;
        end
    end

endmodule

`default_nettype wire

// File: verilog/instrDecoder.sv
// Opcode decode table and decode register
// Unknown opcodes decode as a one cycle NOP
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  wire                             Clk,
    input  wire                             rst,
    input  wire                             load,     // Fetch completing this edge
    input  wire [cpuPkg::dataWidth-1:0]     DI,
    output logic [cpuPkg::uAddrWidth-1:0]   entry,    // Unregistered, for dispatch
    output cpuPkg::decodeT                  dec
);

    cpuPkg::decodeT lookup;

    always_comb
    begin
        lookup = '{cpuPkg::aluNone, cpuPkg::uFetch};  // NOP, CLC, SEC and undefined
        case (DI)
            cpuPkg::opLdaImm: lookup = '{cpuPkg::aluLoad, cpuPkg::uImm};
            cpuPkg::opAdcImm: lookup = '{cpuPkg::aluAdd,  cpuPkg::uImm};
            cpuPkg::opAndImm: lookup = '{cpuPkg::aluAnd,  cpuPkg::uImm};
            cpuPkg::opOraImm: lookup = '{cpuPkg::aluOr,   cpuPkg::uImm};
            cpuPkg::opEorImm: lookup = '{cpuPkg::aluXor,  cpuPkg::uImm};
            cpuPkg::opLdaAbs: lookup = '{cpuPkg::aluLoad, cpuPkg::uLdaLo};
            cpuPkg::opStaAbs: lookup = '{cpuPkg::aluNone, cpuPkg::uStaLo};
            cpuPkg::opJmpAbs: lookup = '{cpuPkg::aluNone, cpuPkg::uJmpLo};
            cpuPkg::opClc:    lookup = '{cpuPkg::aluClc,  cpuPkg::uFetch};
            cpuPkg::opSec:    lookup = '{cpuPkg::aluSec,  cpuPkg::uFetch};
            default:          ;
        endcase
    end

    assign entry = lookup.entry;

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            dec <= '{cpuPkg::aluNone, cpuPkg::uFetch};
        end
        else if (load)
        begin
            dec <= lookup;                            // Held until the next fetch
        end
    end

endmodule

`default_nettype wire

// File: verilog/addrGen.sv
// Program counter, memory address register and address output select
// On naMarFromOps and naPcFromOps the operand pair drives AO directly
// PC wraps at 64K
`timescale 1ns/1ps
`default_nettype none

module addrGen (
    input  wire                             Clk,
    input  wire                             rst,
    input  wire                             rdy,
    input  wire cpuPkg::naOpE               naOp,
    input  wire [cpuPkg::dataWidth-1:0]     op1,      // Low byte
    input  wire [cpuPkg::dataWidth-1:0]     op2,      // High byte
    output logic [cpuPkg::addrWidth-1:0]    AO
);

    logic [cpuPkg::addrWidth-1:0] pc;
    logic [cpuPkg::addrWidth-1:0] mar;
    logic [cpuPkg::addrWidth-1:0] opsAddr;

    assign opsAddr = {op2, op1};

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            pc <= cpuPkg::resetVector;
        end
        else if (rdy)
        begin
            case (naOp)
                cpuPkg::naPcInc:     pc <= pc + 1'b1;
                cpuPkg::naPcFromOps: pc <= opsAddr + 1'b1;    // Past the JMP target
                default:             ;
            endcase
        end
    end

    always_ff @(posedge Clk)
    begin
        if (rdy && naOp == cpuPkg::naMarFromOps)
        begin
            mar <= opsAddr;
        end
    end

    // Address out, stable while Wait stalls the core
    always_comb
    begin
        case (naOp)
            cpuPkg::naUseMar:     AO = mar;
            cpuPkg::naMarFromOps: AO = opsAddr;       // Bypass of the MAR load
            cpuPkg::naPcFromOps:  AO = opsAddr;       // Opcode fetch at the JMP target
            default:              AO = pc;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
// Accumulator ALU with N, Z and C flags
// No overflow flag and no decimal mode
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire                             Clk,
    input  wire                             rst,
    input  wire                             exec,     // aluEn qualified by Rdy
    input  wire cpuPkg::aluOpE              aluOp,
    input  wire [cpuPkg::dataWidth-1:0]     operand,
    output logic [cpuPkg::dataWidth-1:0]    A,
    output cpuPkg::flagsT                   flags
);

    logic [cpuPkg::dataWidth:0]   sum;                // Carry out in the top bit
    logic [cpuPkg::dataWidth-1:0] result;
    logic                         newC;
    logic                         updNz;

    assign sum = {1'b0, A} + {1'b0, operand} + {{cpuPkg::dataWidth{1'b0}}, flags.c};

    always_comb
    begin
        result = A;
        newC   = flags.c;
        updNz  = 1'b1;
        case (aluOp)
            cpuPkg::aluLoad: result = operand;
            cpuPkg::aluAdd:
            begin
                result = sum[cpuPkg::dataWidth-1:0];
                newC   = sum[cpuPkg::dataWidth];
            end
            cpuPkg::aluAnd:  result = A & operand;
            cpuPkg::aluOr:   result = A | operand;
            cpuPkg::aluXor:  result = A ^ operand;
            cpuPkg::aluClc:
            begin
                newC  = 1'b0;
                updNz = 1'b0;                         // Carry only
            end
            cpuPkg::aluSec:
            begin
                newC  = 1'b1;
                updNz = 1'b0;
            end
            default: updNz = 1'b0;                    // aluNone leaves everything
        endcase
    end

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            A     <= '0;
            flags <= '0;
        end
        else if (exec)
        begin
            A       <= result;
            flags.c <= newC;
            if (updNz)
            begin
                flags.n <= result[cpuPkg::dataWidth-1];
                flags.z <= ~|result;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/cpuCore.sv
// Microprogrammed 8-bit core running a small 6502 subset
// Memory stretches any bus cycle by holding Wait high, the whole core stalls
// The ALU op of one instruction completes during the next opcode fetch
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  wire                             Clk,
    input  wire                             rst,
    input  wire                             Wait,     // Memory not ready
    input  wire [cpuPkg::dataWidth-1:0]     DI,
    output cpuPkg::ioOpE                    IO_Op,
    output logic [cpuPkg::addrWidth-1:0]    AO,
    output logic [cpuPkg::dataWidth-1:0]    DO,
    output logic                            Done,     // Pulse after each fetch
    output logic [cpuPkg::dataWidth-1:0]    A,
    output cpuPkg::flagsT                   flags
);

    logic                             rdy;            // Clock enable for all state
    logic                             fetchDone;
    logic                             exec;
    cpuPkg::microWordT                uWord;
    cpuPkg::decodeT                   dec;
    logic [cpuPkg::uAddrWidth-1:0]    uAddr;
    logic [cpuPkg::uAddrWidth-1:0]    entry;
    logic [cpuPkg::dataWidth-1:0]     op1;
    logic [cpuPkg::dataWidth-1:0]     op2;

    ////////////////////////////////////////////////////////////////////////////
    // Bus handshake and strobes

    assign IO_Op     = uWord.ioOp;
    assign rdy       = (uWord.ioOp == cpuPkg::ioNone) | ~Wait;
    assign fetchDone = (uWord.ioOp == cpuPkg::ioFetch) & rdy;
    assign exec      = uWord.aluEn & rdy;
    assign DO        = A;                             // STA is the only writer

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            Done <= 1'b0;
        end
        else
        begin
            Done <= fetchDone;
        end
    end

    // Operand registers
    always_ff @(posedge Clk)
    begin
        if (rdy && uWord.ldOp1)
        begin
            op1 <= DI;
        end
        if (rdy && uWord.ldOp2)
        begin
            op2 <= DI;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath and control blocks

    microSequencer microSequencer_inst (
        .Clk   (Clk),
        .rst   (rst),
        .rdy   (rdy),
        .uWord (uWord),
        .entry (entry),
        .uAddr (uAddr)
    );

    microProgramRom microProgramRom_inst (
        .Clk   (Clk),
        .rst   (rst),
        .rdy   (rdy),
        .uAddr (uAddr),
        .uWord (uWord)
    );

    instrDecoder instrDecoder_inst (
        .Clk   (Clk),
        .rst   (rst),
        .load  (fetchDone),
        .DI    (DI),
        .entry (entry),
        .dec   (dec)
    );

    addrGen addrGen_inst (
        .Clk  (Clk),
        .rst  (rst),
        .rdy  (rdy),
        .naOp (uWord.naOp),
        .op1  (op1),
        .op2  (op2),
        .AO   (AO)
    );

    alu alu_inst (
        .Clk     (Clk),
        .rst     (rst),
        .exec    (exec),
        .aluOp   (dec.aluOp),
        .operand (op1),
        .A       (A),
        .flags   (flags)
    );

endmodule

`default_nettype wire

// File: test/tbClock.sv
// Testbench clock, 10 ns period, with a synchronous reset held for 5 cycles
// A resetReq high on a rising edge starts another 5 cycle reset
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    input  wire  resetReq,
    output logic Clk,
    output wire  rst
);

    int rstLeft = 5;                                  // Reset cycles still to go

    initial Clk = 1'b0;
    always #5 Clk = ~Clk;

    always @(posedge Clk)
    begin
        if (resetReq)
        begin
            rstLeft <= 5;
        end
        else if (rstLeft > 0)
        begin
            rstLeft <= rstLeft - 1;
        end
    end

    assign rst = (rstLeft != 0);

endmodule

`default_nettype wire

// File: test/cpuCore_sva.sv
// Bus protocol properties, bound into every cpuCore instance
// All properties sample on the rising clock edge
`timescale 1ns/1ps
`default_nettype none

module cpuCore_sva (
    input wire                              Clk,
    input wire                              rst,
    input wire                              Wait,
    input wire cpuPkg::ioOpE                IO_Op,
    input wire [cpuPkg::addrWidth-1:0]      AO,
    input wire                              Done
);

    // Stalled bus cycle keeps its operation and address
    stallHold: assert property (@(posedge Clk) disable iff (rst)
        (IO_Op != cpuPkg::ioNone && Wait) |=> ($stable(IO_Op) && $stable(AO)))
    else $error("bus cycle changed while Wait was high");

    // First cycle out of reset is an opcode fetch
    fetchAfterReset: assert property (@(posedge Clk)
        rst |=> (IO_Op == cpuPkg::ioFetch))
    else $error("no opcode fetch in the cycle after reset");

    // Done only follows a completed fetch, one cycle later
    doneAfterFetch: assert property (@(posedge Clk) disable iff (rst)
        Done |-> $past(IO_Op == cpuPkg::ioFetch && !Wait && !rst))
    else $error("Done high without a completed fetch");

endmodule

bind cpuCore cpuCore_sva cpuCore_sva_inst (
    .Clk   (Clk),
    .rst   (rst),
    .Wait  (Wait),
    .IO_Op (IO_Op),
    .AO    (AO),
    .Done  (Done)
);

`default_nettype wire

// File: test/tbCpuCore.sv
// Directed tests for cpuCore against a 64 KB memory model
// Expected values come from a behavioural model of the instruction subset
// Random Wait and the random immediate program share one seed
`timescale 1ns/1ps
`default_nettype none

module tbCpuCore;

    typedef struct packed {
        logic [cpuPkg::addrWidth-1:0] addr;
        logic [cpuPkg::dataWidth-1:0] data;
    } busWriteT;

    localparam int timeoutCycles = 2000;

    logic                           resetReq;
    logic                           Clk;
    wire                            rst;
    logic                           Wait;
    logic [cpuPkg::dataWidth-1:0]   DI;
    cpuPkg::ioOpE                   IO_Op;
    logic [cpuPkg::addrWidth-1:0]   AO;
    logic [cpuPkg::dataWidth-1:0]   DO;
    logic                           Done;
    logic [cpuPkg::dataWidth-1:0]   A;
    cpuPkg::flagsT                  flags;

    logic [cpuPkg::dataWidth-1:0]   mem [0:65535];
    integer                         seed = 32'hdb33dc1d;
    bit                             randomWait;        // Wait off or random
    int                             cycle;             // Cycles since reset release
    int                             doneCycles[$];     // Cycle of each Done pulse
    logic [cpuPkg::addrWidth-1:0]   fetchAddrs[$];     // Completed fetches
    busWriteT                       writes[$];         // Completed writes
    logic [7:0]                     prog[$];           // Bytes for loadProgram
    logic [7:0]                     timedOps[$];       // Opcodes whose length is checked
    logic [7:0]                     immOps[$];
    logic [7:0]                     immVals[$];
    logic [7:0]                     modelA;
    cpuPkg::flagsT                  modelFlags;
    int                             checkCount;
    int                             errorCount;
    int                             timeoutCount;

    tbClock tbClock_inst (.resetReq(resetReq), .Clk(Clk), .rst(rst));

    cpuCore cpuCore_inst (
        .Clk   (Clk),
        .rst   (rst),
        .Wait  (Wait),
        .DI    (DI),
        .IO_Op (IO_Op),
        .AO    (AO),
        .DO    (DO),
        .Done  (Done),
        .A     (A),
        .flags (flags)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory model and bus monitor

    always @(posedge Clk)
    begin
        #1;
        if (randomWait)
        begin
            Wait = ({$random(seed)} % 3) == 0;            // About one cycle in three
        end
        else
        begin
            Wait = 1'b0;
        end
        DI = mem[AO];                                     // Read answered in the cycle
    end

    // Mid cycle, so the values are those the next edge completes
    always @(negedge Clk)
    begin
        if (!rst)
        begin
            cycle++;
            if (Done)
            begin
                doneCycles.push_back(cycle);
            end
            if (IO_Op == cpuPkg::ioFetch && !Wait)
            begin
                fetchAddrs.push_back(AO);
            end
            if (IO_Op == cpuPkg::ioWrite && !Wait)
            begin
                writes.push_back('{addr: AO, data: DO});
                mem[AO] = DO;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers and reference model

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        checkCount++;
        assert (got == exp)
        else
        begin
            errorCount++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic fillMemory();
        int a;
        for (a = 0; a < 65536; a++)
        begin
            mem[a] = a[7:0] ^ a[15:8] ^ 8'h3c;            // Mixes both address bytes
        end
    endtask

    task automatic loadProgram(input logic [15:0] base);
        int k;
        for (k = 0; k < prog.size(); k++)
        begin
            mem[base + k[15:0]] = prog[k];
        end
    endtask

    task automatic resetCore();
        int n;
        @(posedge Clk);
        #1;
        resetReq = 1'b1;
        @(posedge Clk);
        #1;
        resetReq = 1'b0;                                  // rst is high from here
        doneCycles.delete();
        fetchAddrs.delete();
        writes.delete();
        cycle = 0;
        n = 0;
        while (rst && n < timeoutCycles)
        begin
            @(posedge Clk);
            #1;
            n++;
        end
        if (rst)
        begin
            timeoutCount++;
            $display("timeout: reset still active after %0d cycles", timeoutCycles);
        end
    endtask

    task automatic waitForDones(input int count);
        int n;
        n = 0;
        while (doneCycles.size() < count && n < timeoutCycles)
        begin
            @(negedge Clk);
            #1;                                           // Monitor has logged this cycle
            n++;
        end
        if (doneCycles.size() < count)
        begin
            timeoutCount++;
            $display("timeout: saw %0d of %0d Done pulses in %0d cycles",
                     doneCycles.size(), count, timeoutCycles);
        end
    endtask

    task automatic runProgram(input int doneCount, input bit withWait);
        randomWait = withWait;
        resetCore();
        waitForDones(doneCount);
    endtask

    // Cycle counts from fetch to next fetch at zero Wait
    function automatic int cyclesFor(input logic [7:0] op);
        case (op)
            cpuPkg::opLdaImm, cpuPkg::opAdcImm, cpuPkg::opAndImm,
            cpuPkg::opOraImm, cpuPkg::opEorImm: return 2;
            cpuPkg::opJmpAbs:                    return 3;
            cpuPkg::opLdaAbs, cpuPkg::opStaAbs:  return 4;
            default:                             return 1;   // NOP, CLC, SEC, undefined
        endcase
    endfunction

    // Instruction set behaviour, one instruction per call
    task automatic applyModel(input logic [7:0] op, input logic [7:0] val);
        logic [8:0] sum;
        sum = modelA + val + modelFlags.c;
        case (op)
            cpuPkg::opLdaImm, cpuPkg::opLdaAbs: modelA = val;
            cpuPkg::opAdcImm:
            begin
                modelA       = sum[7:0];
                modelFlags.c = sum[8];
            end
            cpuPkg::opAndImm: modelA = modelA & val;
            cpuPkg::opOraImm: modelA = modelA | val;
            cpuPkg::opEorImm: modelA = modelA ^ val;
            cpuPkg::opClc:    modelFlags.c = 1'b0;
            cpuPkg::opSec:    modelFlags.c = 1'b1;
            default:          ;
        endcase
        if (op inside {cpuPkg::opLdaImm, cpuPkg::opLdaAbs, cpuPkg::opAdcImm,
                       cpuPkg::opAndImm, cpuPkg::opOraImm, cpuPkg::opEorImm})
        begin
            modelFlags.n = modelA[7];
            modelFlags.z = (modelA == 8'h00);
        end
    endtask

    task automatic checkState();
        checkValue(A, modelA, "A");
        checkValue(flags, modelFlags, "flags NZC");
    endtask

    task automatic checkIntervals();
        int k;
        for (k = 0; k < timedOps.size() && k + 1 < doneCycles.size(); k++)
        begin
            checkValue(doneCycles[k + 1] - doneCycles[k], cyclesFor(timedOps[k]),
                       $sformatf("cycles of opcode %02h", timedOps[k]));
        end
    endtask

    task automatic generateImmediate(input int count);
        int          k;
        logic [31:0] r;
        for (k = 0; k < count; k++)
        begin
            r = $random(seed);
            case (r % 7)
                0:       immOps.push_back(cpuPkg::opLdaImm);
                1:       immOps.push_back(cpuPkg::opAdcImm);
                2:       immOps.push_back(cpuPkg::opAndImm);
                3:       immOps.push_back(cpuPkg::opOraImm);
                4:       immOps.push_back(cpuPkg::opEorImm);
                5:       immOps.push_back(cpuPkg::opClc);
                default: immOps.push_back(cpuPkg::opSec);
            endcase
            r = $random(seed);
            immVals.push_back(r[7:0]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic testTiming();
        fillMemory();
        // NOP CLC SEC undefined LDA# ADC# JMP $0210
        prog = {8'hEA, 8'h18, 8'h38, 8'hFF, 8'hA9, 8'h11, 8'h69, 8'h22, 8'h4C, 8'h10, 8'h02};
        loadProgram(cpuPkg::resetVector);
        prog = {8'hAD, 8'h00, 8'h03, 8'h8D, 8'h01, 8'h03, 8'hEA, 8'hEA};   // LDA STA NOP
        loadProgram(16'h0210);
        timedOps = {8'hEA, 8'h18, 8'h38, 8'hFF, 8'hA9, 8'h69, 8'h4C, 8'hAD, 8'h8D};
        runProgram(timedOps.size() + 1, 1'b0);
        if (fetchAddrs.size() > 0)
        begin
            checkValue(fetchAddrs[0], cpuPkg::resetVector, "first fetch address");
        end
        checkIntervals();
    endtask

    task automatic testJump();
        fillMemory();
        prog = {8'h4C, 8'h80, 8'h04};                     // JMP $0480
        loadProgram(cpuPkg::resetVector);
        prog = {8'hEA, 8'hEA, 8'hEA};
        loadProgram(16'h0480);
        runProgram(3, 1'b0);
        if (fetchAddrs.size() > 1)
        begin
            checkValue(fetchAddrs[1], 16'h0480, "fetch address after JMP");
        end
    endtask

    task automatic testUndefined();
        fillMemory();
        prog = {8'hA9, 8'h80, 8'h38, 8'h02, 8'hFF, 8'h00, 8'h8A, 8'hEA, 8'hEA};
        loadProgram(cpuPkg::resetVector);
        timedOps = {8'hA9, 8'h38, 8'h02, 8'hFF, 8'h00, 8'h8A};
        runProgram(timedOps.size() + 1, 1'b0);
        checkIntervals();
        modelA     = 8'h00;
        modelFlags = '0;
        applyModel(cpuPkg::opLdaImm, 8'h80);
        applyModel(cpuPkg::opSec, 8'h00);                 // Undefined ones change nothing
        checkState();
        checkValue(writes.size(), 0, "write count");
    endtask

    task automatic testImmediate(input bit withWait);
        int k;
        fillMemory();
        prog.delete();
        modelA     = 8'h00;
        modelFlags = '0;
        for (k = 0; k < immOps.size(); k++)
        begin
            prog.push_back(immOps[k]);
            if (immOps[k] != cpuPkg::opClc && immOps[k] != cpuPkg::opSec)
            begin
                prog.push_back(immVals[k]);
            end
            applyModel(immOps[k], immVals[k]);
        end
        prog.push_back(cpuPkg::opNop);
        prog.push_back(cpuPkg::opNop);
        loadProgram(cpuPkg::resetVector);
        runProgram(immOps.size() + 1, withWait);
        checkState();
        checkValue(writes.size(), 0, "write count");
    endtask

    task automatic testLoadStore(input bit withWait);
        fillMemory();
        mem[16'h1234] = 8'hC3;
        prog = {8'hAD, 8'h34, 8'h12, 8'h8D, 8'h78, 8'h56, 8'hEA, 8'hEA};   // LDA STA
        loadProgram(cpuPkg::resetVector);
        runProgram(3, withWait);
        checkValue(writes.size(), 1, "write count");
        if (writes.size() > 0)
        begin
            checkValue(writes[0].addr, 16'h5678, "write address");
            checkValue(writes[0].data, 8'hC3, "write data");
        end
        checkValue(mem[16'h5678], 8'hC3, "stored byte");
        modelA     = 8'h00;
        modelFlags = '0;
        applyModel(cpuPkg::opLdaAbs, 8'hC3);
        checkState();
    endtask

    initial
    begin
        resetReq     = 1'b0;
        Wait         = 1'b0;
        DI           = 8'h00;
        randomWait   = 1'b0;
        cycle        = 0;
        checkCount   = 0;
        errorCount   = 0;
        timeoutCount = 0;
        generateImmediate(24);
        testTiming();
        testJump();
        testUndefined();
        testImmediate(1'b0);
        testLoadStore(1'b0);
        testImmediate(1'b1);                              // Same program, random Wait
        testLoadStore(1'b1);
        $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
verilog/cpuPkg.sv
verilog/microSequencer.sv
verilog/microProgramRom.sv
verilog/instrDecoder.sv
verilog/addrGen.sv
verilog/alu.sv
verilog/cpuCore.sv
test/tbClock.sv
test/cpuCore_sva.sv
test/tbCpuCore.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbCpuCore
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
